//--- rv_mc.f
hw/rv_mc_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/immediate.sv
hw/csr.sv
hw/control.sv
hw/datapath.sv
verification/tb_clock.sv
verification/tb_rv_mc.sv

//--- Makefile
TOP = tb_rv_mc

all: run

build:
	verilator --binary --timing -j 0 -f rv_mc.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

lint:
	verilator --lint-only --timing -Wall -f rv_mc.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- verification/tb_rv_mc.sv
`timescale 1ns/1ns

module tb_rv_mc;
	localparam int RAND_FIRST = 31;  // After base and register init
	localparam int RAND_LAST = 230;
	localparam int TAIL = 231;

	logic                clk;
	logic                reset;
	rv_mc_pkg::mem_req_t mem_req;
	logic [31:0]         mem_rd_data;

	logic [7:0]  mem [logic [31:0]];
	logic [7:0]  saved_mem [logic [31:0]];
	logic [31:0] rand_state = 32'hd94d;
	int          kind [0:TAIL];
	logic [31:0] trace_pc [$];
	int          trace_cycles [$];
	logic [31:0] st_addr [$];
	logic [1:0]  st_size [$];
	logic [31:0] st_data [$];
	int          cycle_count;
	int          next_fetch;
	int          fetch_idx;
	logic        done = 1'b0;
	int          n;

	tb_clock clock_gen (.clk_o(clk), .reset_o(reset));

	datapath dut_i (
		.clk_i(clk),
		.reset_i(reset),
		.mem_req_o(mem_req),
		.mem_rd_data_i(mem_rd_data)
	);

	function automatic logic [31:0] next_rand();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [31:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
	endfunction

	function automatic logic [31:0] size_mask(input logic [1:0] sz);
		return (sz == 2'd0) ? 32'hff : (sz == 2'd1) ? 32'hffff : 32'hffffffff;
	endfunction

	function automatic logic [31:0] read_mem(input logic [31:0] a, input logic [1:0] sz);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < (1 << sz); k++) begin
			v[8*k +: 8] = mem.exists(a + k) ? mem[a + k] : fill_byte(a + k);
		end
		return v;  // Zero-filled above the size
	endfunction

	task automatic write_mem(input logic [31:0] a, input logic [31:0] d, input logic [1:0] sz);
		for (int k = 0; k < (1 << sz); k++) begin
			mem[a + k] = d[8*k +: 8];
		end
	endtask

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Instruction encoders and program generator
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// Forward offset in bytes that never lands on a jalr slot
	function automatic int pick_target(input int i);
		int t;
		t = i + 1 + int'(next_rand() % 8);
		if (t > TAIL) t = TAIL;
		if (kind[t] == 10) t = t + 1;
		return (t - i) * 4;
	endfunction

	task automatic put_word(input int slot, input logic [31:0] w);
		write_mem(rv_mc_pkg::RESET_PC + 32'(4 * slot), w, 2'd2);
	endtask

	task automatic build_program();
		logic [31:0] r;
		logic [31:0] q;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  base;
		logic [2:0]  f3;
		logic [11:0] imm;
		int          i;
		int          off;
		base = 5'd0;
		for (i = 0; i <= TAIL; i++) kind[i] = 0;
		i = RAND_FIRST;
		while (i <= RAND_LAST) begin
			kind[i] = int'(next_rand() % 10);
			if (kind[i] == 9 && i < RAND_LAST) begin
				kind[i + 1] = 10;  // auipc then jalr
				i = i + 1;
			end else if (kind[i] == 9) begin
				kind[i] = 0;
			end
			i = i + 1;
		end
		put_word(0, {20'h00020, 5'd31, 7'h37});  // Data base in x31
		for (i = 1; i < RAND_FIRST; i++) begin
			r = next_rand();
			put_word(i, encode_i(r[11:0], 5'd0, 3'd0, 5'(i), 7'h13));
		end
		for (i = RAND_FIRST; i <= RAND_LAST; i++) begin
			r = next_rand();
			q = next_rand();
			rd = 5'(r % 31);
			rs1 = r[9:5];
			rs2 = r[14:10];
			f3 = r[17:15];
			imm = q[11:0];
			case (kind[i])
			0: begin
				if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
				if (f3 == 3'd5) imm = {1'b0, imm[11], 5'd0, imm[4:0]};
				put_word(i, encode_i(imm, rs1, f3, rd, 7'h13));
			end
			1: begin
				if (f3 == 3'd1 || f3 == 3'd5) f3 = 3'd0;
				put_word(i, {(f3 == 3'd0 && r[20]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33});
			end
			2: put_word(i, {q[31:12], rd, 7'h37});
			3: put_word(i, {q[31:12], rd, 7'h17});
			4: begin
				f3 = 3'(r[20:18] % 5);
				if (f3 > 3'd2) f3 = f3 + 3'd1;  // lb lh lw lbu lhu
				imm = {4'd0, q[7:0] & ~8'((1 << f3[1:0]) - 1)};
				put_word(i, encode_i(imm, 5'd31, f3, rd, 7'h03));
			end
			5: begin
				f3 = 3'(r[20:18] % 3);
				imm = {4'd0, q[7:0] & ~8'((1 << f3[1:0]) - 1)};
				put_word(i, encode_s(imm, rs2, 5'd31, f3));
			end
			6: begin
				f3 = 3'(r[20:18] % 6);
				if (f3 > 3'd1) f3 = f3 + 3'd2;
				put_word(i, encode_b(13'(pick_target(i)), rs2, rs1, f3));
			end
			7: put_word(i, encode_j(21'(pick_target(i)), rd));
			8: begin
				if (q[13:12] == 2'd0) begin
					put_word(i, encode_i(rv_mc_pkg::CSR_MINSTRET, 5'd0, 3'd2, rd, 7'h73));
				end else begin
					put_word(i, encode_i(rv_mc_pkg::CSR_MSCRATCH, rs1, {1'b0, q[14] ? 2'd1 : 2'd2},
						rd, 7'h73));
				end
			end
			9: begin
				base = 5'(1 + r % 30);
				put_word(i, {20'd0, base, 7'h17});
			end
			default: begin
				off = pick_target(i) + 4;  // Relative to the auipc
				put_word(i, encode_i(12'(off), base, 3'd0, rd, 7'h67));
			end
			endcase
		end
		// Signature of x1..x30, mscratch and minstret, then self-loop
		for (i = 1; i <= 30; i++) begin
			put_word(TAIL + i - 1, encode_s(12'(256 + 4 * (i - 1)), 5'(i), 5'd31, 3'd2));
		end
		put_word(TAIL + 30, encode_i(rv_mc_pkg::CSR_MSCRATCH, 5'd0, 3'd2, 5'd1, 7'h73));
		put_word(TAIL + 31, encode_s(12'd376, 5'd1, 5'd31, 3'd2));
		put_word(TAIL + 32, encode_i(rv_mc_pkg::CSR_MINSTRET, 5'd0, 3'd2, 5'd1, 7'h73));
		put_word(TAIL + 33, encode_s(12'd380, 5'd1, 5'd31, 3'd2));
		put_word(TAIL + 34, encode_j(21'd0, 5'd0));
	endtask

	////////////////////////////////////////////////////////////
	// Instruction-set model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b, input logic alt);
		case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'd0, $signed(a) < $signed(b)};
		3'd3: return {31'd0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
		endcase
	endfunction

	task automatic run_model();
		logic [31:0] x [0:31];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] npc;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] old;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] mscratch;
		logic [31:0] minstret;
		logic [2:0]  f3;
		logic        wr;
		logic        taken;
		logic        bump;
		for (int k = 0; k < 32; k++) x[k] = '0;
		pc = rv_mc_pkg::RESET_PC;
		mscratch = '0;
		minstret = '0;
		for (int k = 0; k < 1000; k++) begin
			w = read_mem(pc, 2'd2);
			f3 = w[14:12];
			a = x[w[19:15]];
			b = x[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			npc = pc + 32'd4;
			res = '0;
			wr = 1'b1;
			bump = 1'b1;
			trace_pc.push_back(pc);
			trace_cycles.push_back(w[6:0] == 7'h03 ? 6 : 4);
			if (w == 32'h0000006f) break;
			case (w[6:0])
			7'h37: res = {w[31:12], 12'd0};
			7'h17: res = pc + {w[31:12], 12'd0};
			7'h6f: begin
				res = pc + 32'd4;
				npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			7'h67: begin
				res = pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
			end
			7'h63: begin
				wr = 1'b0;
				case (f3)
				3'd0: taken = a == b;
				3'd1: taken = a != b;
				3'd4: taken = $signed(a) < $signed(b);
				3'd5: taken = $signed(a) >= $signed(b);
				3'd6: taken = a < b;
				default: taken = a >= b;
				endcase
				if (taken) npc = pc + imm_b;
			end
			7'h03: begin
				res = read_mem(a + imm_i, f3[1:0]);
				if (f3 == 3'd0) res = {{24{res[7]}}, res[7:0]};
				if (f3 == 3'd1) res = {{16{res[15]}}, res[15:0]};
			end
			7'h23: begin
				wr = 1'b0;
				addr = a + imm_s;
				st_addr.push_back(addr);
				st_size.push_back(f3[1:0]);
				st_data.push_back(b & size_mask(f3[1:0]));
				write_mem(addr, b, f3[1:0]);
			end
			7'h13: res = alu_ref(f3, a, imm_i, f3 == 3'd5 && w[30]);
			7'h33: res = alu_ref(f3, a, b, w[30]);
			7'h73: begin
				old = (w[31:20] == rv_mc_pkg::CSR_MSCRATCH) ? mscratch :
					(w[31:20] == rv_mc_pkg::CSR_MINSTRET) ? minstret : 32'd0;
				res = old;
				if (f3 == 3'd1 || w[19:15] != 5'd0) begin
					if (w[31:20] == rv_mc_pkg::CSR_MSCRATCH) mscratch = (f3 == 3'd1) ? a : old | a;
					if (w[31:20] == rv_mc_pkg::CSR_MINSTRET) begin
						minstret = (f3 == 3'd1) ? a : old | a;
						bump = 1'b0;
					end
				end
			end
			default: wr = 1'b0;  // Unknown opcode
			endcase
			if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
			if (bump) minstret = minstret + 32'd1;
			pc = npc;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Memory model and DUT monitor
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			cycle_count = 0;
			next_fetch = 0;
			fetch_idx = 0;
		end else begin
			if (mem_req.wr_enable) begin
				if (st_addr.size() == 0) begin
					$display("Store strobe at %0t with no store left in the model", $time);
					stop_run();
				end
				check_value("wr_addr", st_addr.pop_front(), mem_req.wr_addr);
				check_value("wr_size", {30'd0, st_size.pop_front()}, {30'd0, mem_req.wr_size});
				check_value("wr_data", st_data.pop_front(),
					mem_req.wr_data & size_mask(mem_req.wr_size));
				write_mem(mem_req.wr_addr, mem_req.wr_data, mem_req.wr_size);
			end
			mem_rd_data <= read_mem(mem_req.rd_addr, mem_req.rd_size);
			if (fetch_idx < trace_pc.size() && cycle_count == next_fetch) begin
				check_value("fetch rd_addr", trace_pc[fetch_idx], mem_req.rd_addr);
				check_value("fetch rd_size", 32'd2, {30'd0, mem_req.rd_size});
				next_fetch = next_fetch + trace_cycles[fetch_idx];
				fetch_idx = fetch_idx + 1;
				if (fetch_idx == trace_pc.size()) done <= 1'b1;
			end
			cycle_count = cycle_count + 1;
		end
	end

	initial begin
		mem_rd_data = '0;
		build_program();
		saved_mem = mem;
		run_model();
		mem = saved_mem;  // DUT starts from the clean program image
		for (n = 0; n < 4000 && !done; n++) begin
			@(posedge clk);
		end
		if (!done) begin
			$display("The core never reached the end loop within 4000 cycles");
			stop_run();
		end else if (st_addr.size() != 0) begin
			$display("The core reached the end loop with %0d stores missing", st_addr.size());
			stop_run();
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk_o,
	output logic reset_o
);
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;  // 8 ns period
	end

	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

//--- hw/datapath.sv
`timescale 1ns/1ns

module datapath (
	input  logic                clk_i,
	input  logic                reset_i,
	output rv_mc_pkg::mem_req_t mem_req_o,
	input  logic [31:0]         mem_rd_data_i
);
	rv_mc_pkg::instruction_t ir;
	logic [31:0] pc;
	logic [31:0] pc_4;
	logic [31:0] next_pc;
	logic [31:0] rf_rin;
	logic [31:0] rf_rout1;
	logic [31:0] rf_rout2;
	logic [31:0] imm;
	logic [31:0] alu_in1;
	logic [31:0] alu_in2;
	logic [31:0] alu_out;
	logic        cmp_res;
	logic [31:0] csr_dout;

	logic                          ctrl_pc_we;
	logic                          ctrl_ir_we;
	logic                          ctrl_regfile_we;
	logic                          ctrl_csr_we;
	logic                          ctrl_retire;
	rv_mc_pkg::next_pc_sel_t       ctrl_next_pc_sel;
	rv_mc_pkg::regfile_in_sel_t    ctrl_regfile_in_sel;
	rv_mc_pkg::mem_rd_addr_sel_t   ctrl_mem_rd_addr_sel;
	rv_mc_pkg::alu_op_t            ctrl_alu_op;
	rv_mc_pkg::alu_in1_sel_t       ctrl_alu_in1_sel;
	rv_mc_pkg::alu_in2_sel_t       ctrl_alu_in2_sel;
	rv_mc_pkg::compare_op_t        ctrl_compare_op;
	rv_mc_pkg::mem_size_t          ctrl_rd_size;
	rv_mc_pkg::mem_size_t          ctrl_wr_size;
	logic                          ctrl_wr_enable;

	assign pc_4 = pc + 32'd4;

	regfile regfile_i (
		.clk_i(clk_i),
		.rs1_i(ir.common.rs1),
		.rs2_i(ir.common.rs2),
		.rd_i(ir.common.rd),
		.rin_i(rf_rin),
		.we_i(ctrl_regfile_we),
		.rout1_o(rf_rout1),
		.rout2_o(rf_rout2)
	);

	immediate immediate_i (
		.instr_i(ir),
		.imm_o(imm)
	);

	control control_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ir_i(ir),
		.cmp_res_i(cmp_res),
		.pc_we_o(ctrl_pc_we),
		.ir_we_o(ctrl_ir_we),
		.regfile_we_o(ctrl_regfile_we),
		.csr_we_o(ctrl_csr_we),
		.retire_o(ctrl_retire),
		.next_pc_sel_o(ctrl_next_pc_sel),
		.regfile_in_sel_o(ctrl_regfile_in_sel),
		.mem_rd_addr_sel_o(ctrl_mem_rd_addr_sel),
		.alu_op_o(ctrl_alu_op),
		.alu_in1_sel_o(ctrl_alu_in1_sel),
		.alu_in2_sel_o(ctrl_alu_in2_sel),
		.compare_op_o(ctrl_compare_op),
		.mem_rd_size_o(ctrl_rd_size),
		.mem_wr_size_o(ctrl_wr_size),
		.mem_wr_enable_o(ctrl_wr_enable)
	);

	alu alu_i (
		.alu_op_i(ctrl_alu_op),
		.compare_op_i(ctrl_compare_op),
		.in1_i(alu_in1),
		.in2_i(alu_in2),
		.cmp1_i(rf_rout1),
		.cmp2_i(rf_rout2),
		.out_o(alu_out),
		.cmp_res_o(cmp_res)
	);

	csr csr_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.sel_i(ir.itype.imm),
		.din_i(alu_out),
		.we_i(ctrl_csr_we),
		.retire_i(ctrl_retire),
		.dout_o(csr_dout)
	);

	////////////////////////////////////////////////////////////
	// Operand and writeback muxes
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl_next_pc_sel)
		rv_mc_pkg::NEXT_PC_SEL_ALU_OUT:     next_pc = {alu_out[31:1], 1'b0};  // jalr
		rv_mc_pkg::NEXT_PC_SEL_COMPARE_OUT: next_pc = alu_out;  // Taken branch
		default:                            next_pc = pc_4;
		endcase

		case (ctrl_regfile_in_sel)
		rv_mc_pkg::REGFILE_IN_SEL_PC_4:   rf_rin = pc_4;
		rv_mc_pkg::REGFILE_IN_SEL_MEM_RD: rf_rin = mem_rd_data_i;
		rv_mc_pkg::REGFILE_IN_SEL_MEM_RD_SEXT8:
			rf_rin = {{24{mem_rd_data_i[7]}}, mem_rd_data_i[7:0]};
		rv_mc_pkg::REGFILE_IN_SEL_MEM_RD_SEXT16:
			rf_rin = {{16{mem_rd_data_i[15]}}, mem_rd_data_i[15:0]};
		rv_mc_pkg::REGFILE_IN_SEL_CSR_OUT: rf_rin = csr_dout;
		default:                           rf_rin = alu_out;
		endcase

		case (ctrl_alu_in1_sel)
		rv_mc_pkg::ALU_IN1_SEL_PC:  alu_in1 = pc;
		rv_mc_pkg::ALU_IN1_SEL_IMM: alu_in1 = imm;
		default:                    alu_in1 = rf_rout1;
		endcase

		case (ctrl_alu_in2_sel)
		rv_mc_pkg::ALU_IN2_SEL_REGFILE_OUT2: alu_in2 = rf_rout2;
		rv_mc_pkg::ALU_IN2_SEL_CSR_OUT:      alu_in2 = csr_dout;
		default:                             alu_in2 = imm;
		endcase

		mem_req_o.rd_addr = (ctrl_mem_rd_addr_sel == rv_mc_pkg::MEM_RD_ADDR_SEL_ALU_OUT) ?
			alu_out : pc;
		mem_req_o.rd_size = ctrl_rd_size;
		mem_req_o.wr_addr = alu_out;
		mem_req_o.wr_data = rf_rout2;
		mem_req_o.wr_size = ctrl_wr_size;
		mem_req_o.wr_enable = ctrl_wr_enable;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= rv_mc_pkg::RESET_PC;
			ir <= '0;  // Decodes as no-op
		end else begin
			if (ctrl_pc_we) begin
				pc <= next_pc;
			end
			if (ctrl_ir_we) begin
				ir <= mem_rd_data_i;
			end
		end
	end

endmodule

//--- hw/control.sv
`timescale 1ns/1ns

module control (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  rv_mc_pkg::instruction_t       ir_i,
	input  logic                          cmp_res_i,
	output logic                          pc_we_o,
	output logic                          ir_we_o,
	output logic                          regfile_we_o,
	output logic                          csr_we_o,
	output logic                          retire_o,
	output rv_mc_pkg::next_pc_sel_t       next_pc_sel_o,
	output rv_mc_pkg::regfile_in_sel_t    regfile_in_sel_o,
	output rv_mc_pkg::mem_rd_addr_sel_t   mem_rd_addr_sel_o,
	output rv_mc_pkg::alu_op_t            alu_op_o,
	output rv_mc_pkg::alu_in1_sel_t       alu_in1_sel_o,
	output rv_mc_pkg::alu_in2_sel_t       alu_in2_sel_o,
	output rv_mc_pkg::compare_op_t        compare_op_o,
	output rv_mc_pkg::mem_size_t          mem_rd_size_o,
	output rv_mc_pkg::mem_size_t          mem_wr_size_o,
	output logic                          mem_wr_enable_o
);
	typedef enum logic [2:0] {
		S_FETCH, S_WAIT, S_DECODE, S_EXEC, S_MEM, S_LOAD_WB
	} state_t;

	state_t               state;
	state_t               state_next;
	rv_mc_pkg::opcode_t   opcode;
	logic [2:0]           funct3;
	logic                 is_load;
	logic                 is_store;
	logic                 writes_rd;
	logic                 csr_wr;
	rv_mc_pkg::mem_size_t load_size;

	assign opcode = ir_i.common.opcode;
	assign funct3 = ir_i.common.funct3;
	assign is_load = opcode == rv_mc_pkg::OPC_LOAD;
	assign retire_o = pc_we_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
		S_FETCH:  state_next = S_WAIT;
		S_WAIT:   state_next = S_DECODE;
		S_DECODE: state_next = S_EXEC;
		S_EXEC:   state_next = is_load ? S_MEM : S_FETCH;
		S_MEM:    state_next = S_LOAD_WB;
		default:  state_next = S_FETCH;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Instruction decode
	////////////////////////////////////////////////////////////
	always_comb begin
		next_pc_sel_o = rv_mc_pkg::NEXT_PC_SEL_PC_4;
		regfile_in_sel_o = rv_mc_pkg::REGFILE_IN_SEL_ALU_OUT;
		alu_op_o = rv_mc_pkg::ALU_ADD;
		alu_in1_sel_o = rv_mc_pkg::ALU_IN1_SEL_REGFILE_OUT1;
		alu_in2_sel_o = rv_mc_pkg::ALU_IN2_SEL_IMM;
		compare_op_o = rv_mc_pkg::CMP_EQ;
		mem_wr_size_o = rv_mc_pkg::mem_size_t'(funct3[1:0]);  // sb/sh/sw
		load_size = rv_mc_pkg::mem_size_t'(funct3[1:0]);
		writes_rd = 1'b0;
		csr_wr = 1'b0;
		is_store = 1'b0;
		case (opcode)
		rv_mc_pkg::OPC_LUI: begin
			alu_in1_sel_o = rv_mc_pkg::ALU_IN1_SEL_IMM;
			alu_op_o = rv_mc_pkg::ALU_PASS2;
			writes_rd = 1'b1;
		end
		rv_mc_pkg::OPC_AUIPC: begin
			alu_in1_sel_o = rv_mc_pkg::ALU_IN1_SEL_PC;
			writes_rd = 1'b1;
		end
		rv_mc_pkg::OPC_JAL, rv_mc_pkg::OPC_JALR: begin
			if (opcode == rv_mc_pkg::OPC_JAL) begin
				alu_in1_sel_o = rv_mc_pkg::ALU_IN1_SEL_PC;
			end
			next_pc_sel_o = rv_mc_pkg::NEXT_PC_SEL_ALU_OUT;
			regfile_in_sel_o = rv_mc_pkg::REGFILE_IN_SEL_PC_4;  // Link
			writes_rd = 1'b1;
		end
		rv_mc_pkg::OPC_BRANCH: begin
			alu_in1_sel_o = rv_mc_pkg::ALU_IN1_SEL_PC;
			compare_op_o = funct3[2] ? rv_mc_pkg::compare_op_t'({1'b0, funct3[1:0]} + 3'd2) :
				rv_mc_pkg::compare_op_t'({2'b00, funct3[0]});
			if (cmp_res_i && funct3[2:1] != 2'b01) begin
				next_pc_sel_o = rv_mc_pkg::NEXT_PC_SEL_COMPARE_OUT;
			end
		end
		rv_mc_pkg::OPC_LOAD: begin
			case (funct3)
			3'b000:  regfile_in_sel_o = rv_mc_pkg::REGFILE_IN_SEL_MEM_RD_SEXT8;
			3'b001:  regfile_in_sel_o = rv_mc_pkg::REGFILE_IN_SEL_MEM_RD_SEXT16;
			default: regfile_in_sel_o = rv_mc_pkg::REGFILE_IN_SEL_MEM_RD;  // Zero-filled
			endcase
		end
		rv_mc_pkg::OPC_STORE: begin
			is_store = 1'b1;
		end
		rv_mc_pkg::OPC_OP_IMM, rv_mc_pkg::OPC_OP: begin
			if (opcode == rv_mc_pkg::OPC_OP) begin
				alu_in2_sel_o = rv_mc_pkg::ALU_IN2_SEL_REGFILE_OUT2;
			end
			case (funct3)
			3'b000: alu_op_o = (opcode == rv_mc_pkg::OPC_OP && ir_i.common.funct7[5]) ?
				rv_mc_pkg::ALU_SUB : rv_mc_pkg::ALU_ADD;
			3'b001: alu_op_o = rv_mc_pkg::ALU_SLL;
			3'b010: alu_op_o = rv_mc_pkg::ALU_SLT;
			3'b011: alu_op_o = rv_mc_pkg::ALU_SLTU;
			3'b100: alu_op_o = rv_mc_pkg::ALU_XOR;
			3'b101: alu_op_o = ir_i.common.funct7[5] ? rv_mc_pkg::ALU_SRA : rv_mc_pkg::ALU_SRL;
			3'b110: alu_op_o = rv_mc_pkg::ALU_OR;
			default: alu_op_o = rv_mc_pkg::ALU_AND;
			endcase
			// Register-amount shifts run as no-ops
			writes_rd = !(opcode == rv_mc_pkg::OPC_OP && funct3[1:0] == 2'b01);
		end
		rv_mc_pkg::OPC_SYSTEM: begin
			if (funct3 == 3'b001 || funct3 == 3'b010) begin
				alu_in2_sel_o = rv_mc_pkg::ALU_IN2_SEL_CSR_OUT;
				alu_op_o = funct3[0] ? rv_mc_pkg::ALU_PASS2 : rv_mc_pkg::ALU_OR;
				regfile_in_sel_o = rv_mc_pkg::REGFILE_IN_SEL_CSR_OUT;
				writes_rd = 1'b1;
				csr_wr = funct3[0] || ir_i.common.rs1 != 5'd0;  // csrrs x0 only reads
			end
		end
		default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Per-state enables and memory port
	////////////////////////////////////////////////////////////
	always_comb begin
		pc_we_o = 1'b0;
		ir_we_o = 1'b0;
		regfile_we_o = 1'b0;
		csr_we_o = 1'b0;
		mem_wr_enable_o = 1'b0;
		mem_rd_addr_sel_o = rv_mc_pkg::MEM_RD_ADDR_SEL_PC;
		mem_rd_size_o = rv_mc_pkg::MEM_SIZE_WORD;
		case (state)
		S_DECODE: ir_we_o = 1'b1;
		S_EXEC: begin
			if (is_load) begin
				mem_rd_addr_sel_o = rv_mc_pkg::MEM_RD_ADDR_SEL_ALU_OUT;
				mem_rd_size_o = load_size;
			end else begin
				pc_we_o = 1'b1;
				regfile_we_o = writes_rd;
				csr_we_o = csr_wr;
				mem_wr_enable_o = is_store;
			end
		end
		S_MEM: begin
			mem_rd_addr_sel_o = rv_mc_pkg::MEM_RD_ADDR_SEL_ALU_OUT;
			mem_rd_size_o = load_size;
		end
		S_LOAD_WB: begin
			pc_we_o = 1'b1;
			regfile_we_o = 1'b1;
		end
		default: ;
		endcase
	end

	// Decode relies on the IR holding between loads
	ir_held_without_load: assert property (
		@(posedge clk_i) disable iff (reset_i) !ir_we_o |=> ir_i == $past(ir_i)
	);

	rf_store_exclusive: assert property (
		@(posedge clk_i) disable iff (reset_i) !(regfile_we_o && mem_wr_enable_o)
	);

endmodule

//--- hw/csr.sv
`timescale 1ns/1ns

module csr (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [11:0] sel_i,
	input  logic [31:0] din_i,
	input  logic        we_i,
	input  logic        retire_i,
	output logic [31:0] dout_o
);
	logic [31:0] mscratch;
	logic [31:0] minstret;
	logic        wr_mscratch;
	logic        wr_minstret;

	assign wr_mscratch = we_i && sel_i == rv_mc_pkg::CSR_MSCRATCH;
	assign wr_minstret = we_i && sel_i == rv_mc_pkg::CSR_MINSTRET;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			mscratch <= 32'd0;
			minstret <= 32'd0;
		end else begin
			if (wr_mscratch) begin
				mscratch <= din_i;
			end
			if (wr_minstret) begin
				minstret <= din_i;  // Write wins over count
			end else if (retire_i) begin
				minstret <= minstret + 32'd1;
			end
		end
	end

	always_comb begin
		case (sel_i)
		rv_mc_pkg::CSR_MSCRATCH: dout_o = mscratch;
		rv_mc_pkg::CSR_MINSTRET: dout_o = minstret;
		default:                 dout_o = 32'd0;  // Unknown CSR
		endcase
	end

endmodule

//--- hw/immediate.sv
`timescale 1ns/1ns

module immediate (
	input  rv_mc_pkg::instruction_t instr_i,
	output logic [31:0]             imm_o
);
	logic [11:0] i_imm;
	logic [6:0]  s_hi;
	logic [4:0]  s_lo;
	logic [19:0] u_imm;

	assign i_imm = instr_i.itype.imm;
	assign s_hi = instr_i.stype.imm_hi;
	assign s_lo = instr_i.stype.imm_lo;
	assign u_imm = instr_i.utype.imm;

	always_comb begin
		case (instr_i.common.opcode)
		rv_mc_pkg::OPC_OP_IMM, rv_mc_pkg::OPC_LOAD, rv_mc_pkg::OPC_JALR:
			imm_o = {{20{i_imm[11]}}, i_imm};
		rv_mc_pkg::OPC_STORE:
			imm_o = {{20{s_hi[6]}}, s_hi, s_lo};
		rv_mc_pkg::OPC_BRANCH:
			imm_o = {{20{s_hi[6]}}, s_lo[0], s_hi[5:0], s_lo[4:1], 1'b0};
		rv_mc_pkg::OPC_LUI, rv_mc_pkg::OPC_AUIPC:
			imm_o = {u_imm, 12'd0};
		rv_mc_pkg::OPC_JAL:
			imm_o = {{12{u_imm[19]}}, u_imm[7:0], u_imm[8], u_imm[18:9], 1'b0};
		rv_mc_pkg::OPC_SYSTEM:
			imm_o = {27'd0, instr_i.common.rs1};  // uimm field
		default:
			imm_o = 32'd0;
		endcase
	end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ns

module alu (
	input  rv_mc_pkg::alu_op_t     alu_op_i,
	input  rv_mc_pkg::compare_op_t compare_op_i,
	input  logic [31:0]            in1_i,
	input  logic [31:0]            in2_i,
	input  logic [31:0]            cmp1_i,
	input  logic [31:0]            cmp2_i,
	output logic [31:0]            out_o,
	output logic                   cmp_res_o
);
	logic [4:0] shamt;

	assign shamt = in2_i[4:0];

	always_comb begin
		case (alu_op_i)
		rv_mc_pkg::ALU_ADD:   out_o = in1_i + in2_i;
		rv_mc_pkg::ALU_SUB:   out_o = in1_i - in2_i;
		rv_mc_pkg::ALU_AND:   out_o = in1_i & in2_i;
		rv_mc_pkg::ALU_OR:    out_o = in1_i | in2_i;
		rv_mc_pkg::ALU_XOR:   out_o = in1_i ^ in2_i;
		rv_mc_pkg::ALU_SLT:   out_o = {31'd0, $signed(in1_i) < $signed(in2_i)};
		rv_mc_pkg::ALU_SLTU:  out_o = {31'd0, in1_i < in2_i};
		rv_mc_pkg::ALU_SLL:   out_o = in1_i << shamt;
		rv_mc_pkg::ALU_SRL:   out_o = in1_i >> shamt;
		rv_mc_pkg::ALU_SRA:   out_o = $unsigned($signed(in1_i) >>> shamt);
		rv_mc_pkg::ALU_PASS2: out_o = in1_i;  // Operand straight through
		default:              out_o = 32'd0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Branch comparator on register operands
	////////////////////////////////////////////////////////////
	always_comb begin
		case (compare_op_i)
		rv_mc_pkg::CMP_EQ:  cmp_res_o = cmp1_i == cmp2_i;
		rv_mc_pkg::CMP_NE:  cmp_res_o = cmp1_i != cmp2_i;
		rv_mc_pkg::CMP_LT:  cmp_res_o = $signed(cmp1_i) < $signed(cmp2_i);
		rv_mc_pkg::CMP_GE:  cmp_res_o = $signed(cmp1_i) >= $signed(cmp2_i);
		rv_mc_pkg::CMP_LTU: cmp_res_o = cmp1_i < cmp2_i;
		rv_mc_pkg::CMP_GEU: cmp_res_o = cmp1_i >= cmp2_i;
		default:            cmp_res_o = 1'b0;
		endcase
	end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ns

module regfile (
	input  logic        clk_i,
	input  logic [4:0]  rs1_i,
	input  logic [4:0]  rs2_i,
	input  logic [4:0]  rd_i,
	input  logic [31:0] rin_i,
	input  logic        we_i,
	output logic [31:0] rout1_o,
	output logic [31:0] rout2_o
);
	logic [31:0] regs [1:31];  // No storage for x0

	always_ff @(posedge clk_i) begin
		if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= rin_i;
		end
	end

	assign rout1_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
	assign rout2_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

	write_then_read: assert property (
		@(posedge clk_i) we_i && rd_i != 5'd0 |=>
			rs1_i != $past(rd_i) || rout1_o == $past(rin_i)
	);

endmodule

//--- hw/rv_mc_pkg.sv
package rv_mc_pkg;

	////////////////////////////////////////////////////////////
	// Core constants
	////////////////////////////////////////////////////////////
	localparam logic [31:0] RESET_PC = 32'h00010000;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MINSTRET = 12'hB02;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} common_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_t     opcode;
	} itype_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} stype_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_t     opcode;
	} utype_t;

	typedef union packed {
		common_t common;
		itype_t  itype;
		stype_t  stype;
		utype_t  utype;
	} instruction_t;

	////////////////////////////////////////////////////////////
	// Datapath selects
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT,
		NEXT_PC_SEL_COMPARE_OUT
	} next_pc_sel_t;

	typedef enum logic [2:0] {
		REGFILE_IN_SEL_ALU_OUT,
		REGFILE_IN_SEL_PC_4,
		REGFILE_IN_SEL_MEM_RD,
		REGFILE_IN_SEL_MEM_RD_SEXT8,
		REGFILE_IN_SEL_MEM_RD_SEXT16,
		REGFILE_IN_SEL_CSR_OUT
	} regfile_in_sel_t;

	typedef enum logic {
		MEM_RD_ADDR_SEL_PC,
		MEM_RD_ADDR_SEL_ALU_OUT
	} mem_rd_addr_sel_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS2
	} alu_op_t;

	typedef enum logic [1:0] {
		ALU_IN1_SEL_REGFILE_OUT1,
		ALU_IN1_SEL_PC,
		ALU_IN1_SEL_IMM
	} alu_in1_sel_t;

	typedef enum logic [1:0] {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IMM,
		ALU_IN2_SEL_CSR_OUT
	} alu_in2_sel_t;

	typedef enum logic [2:0] {
		CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
	} compare_op_t;

	////////////////////////////////////////////////////////////
	// Memory port
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		MEM_SIZE_BYTE,
		MEM_SIZE_HALF,
		MEM_SIZE_WORD
	} mem_size_t;

	typedef struct packed {
		logic [31:0] rd_addr;
		mem_size_t   rd_size;
		logic [31:0] wr_addr;
		logic [31:0] wr_data;
		mem_size_t   wr_size;
		logic        wr_enable;
	} mem_req_t;

endpackage
